/* all.f */
+incdir+hw
hw/spike_delay_pkg.sv
hw/spike_cfg_if.sv
hw/param_decode.sv
hw/delay_line_execute.sv
hw/spike_count_result.sv
hw/spike_delay_top.sv
verification/tb_spike_delay.sv

/* hw/delay_line_execute.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spike_delay_macros.svh"

module delay_line_execute (
    input  logic         i_clk,
    input  logic         i_reset,
    input  logic         i_spike,
    spike_cfg_if.execute cfg,
    output logic         o_spike_raw,
    output logic         o_spike_d1,
    output logic         o_spike_d2
);

    import spike_delay_pkg::*;

    // stage 0 delays the input, stage 1 delays stage 0
    localparam int N_STAGE = 2;

    // one bit history per stage, shared pointer
    logic [`DEPTH_MAX-1:0] mem [N_STAGE];

    ptr_t               ptr_q;
    ptr_t               ptr_cur;
    ptr_t               ptr_inc;
    logic [`PTR_W-1:0]  ptr_idx;
    // cycles of history written, saturates at 2B
    logic [`PTR_W+1:0]  fill_q;
    logic [`PTR_W+1:0]  fill_cur;
    // history needed before each tap is valid
    logic [`PTR_W+1:0]  thr [N_STAGE];
    logic [N_STAGE-1:0] stage_in;
    logic [N_STAGE-1:0] tap;

    ////////////////////////////////////////////////////////////
    // pointer and fill state
    ////////////////////////////////////////////////////////////

    // size change restarts refill in this very cycle
    assign ptr_cur  = cfg.blk_change ? '0 : ptr_q;
    assign fill_cur = cfg.blk_change ? '0 : fill_q;
    assign ptr_idx  = ptr_cur[`PTR_W-1:0];
    assign ptr_inc  = ptr_cur + ptr_t'(1);

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            ptr_q  <= '0;
            fill_q <= '0;
        end
        else
        begin
            // wrap at block size
            if (ptr_inc == cfg.blk_size)
                ptr_q <= '0;
            else
                ptr_q <= ptr_inc;
            // stop counting once both taps are valid
            if (fill_cur < thr[N_STAGE-1])
                fill_q <= fill_cur + 1'b1;
            else
                fill_q <= fill_cur;
        end
    end

    ////////////////////////////////////////////////////////////
    // taps
    ////////////////////////////////////////////////////////////

    // B for the first tap, 2B for the second
    always_comb
    begin
        for (int s = 0; s < N_STAGE; s++)
            thr[s] = {1'b0, cfg.blk_size} << s;
    end

    // entry under the pointer was written B cycles ago
    always_comb
    begin
        for (int s = 0; s < N_STAGE; s++)
            tap[s] = (fill_cur >= thr[s]) ? mem[s][ptr_idx] : 1'b0;
    end

    // second stage takes the masked first tap
    assign stage_in = {tap[0], i_spike};

    ////////////////////////////////////////////////////////////
    // history write
    ////////////////////////////////////////////////////////////

    // read then overwrite the same entry
    always_ff @(posedge i_clk)
    begin
        for (int s = 0; s < N_STAGE; s++)
        begin
            if (cfg.blk_change)
            begin
                // old history dropped, new sample kept
                for (int i = 0; i < `DEPTH_MAX; i++)
                    mem[s][i] <= (i == int'(ptr_idx)) ? stage_in[s] : 1'b0;
            end
            else
                mem[s][ptr_idx] <= stage_in[s];
        end
    end

    assign o_spike_raw = i_spike;
    assign o_spike_d1  = tap[0];
    assign o_spike_d2  = tap[1];

endmodule

`default_nettype wire

/* hw/param_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spike_delay_macros.svh"

module param_decode (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_load,
    input  spike_delay_pkg::code_t i_code,
    input  spike_delay_pkg::word_t i_data,
    spike_cfg_if.decode            cfg
);

    import spike_delay_pkg::*;

    ptr_t   blk_size_q;
    count_t window_len_q;
    logic   blk_change_q;
    logic   window_change_q;
    logic   hit_blk;
    logic   hit_window;
    ptr_t   blk_clamped;
    count_t window_clamped;

    ////////////////////////////////////////////////////////////
    // code match and clamping
    ////////////////////////////////////////////////////////////

    // unknown codes match neither
    assign hit_blk    = i_load && (i_code == code_t'(`CODE_BLK));
    assign hit_window = i_load && (i_code == code_t'(`CODE_WINDOW));

    // block size limited to 1 .. DEPTH_MAX
    always_comb
    begin
        if (i_data == '0)
            blk_clamped = ptr_t'(1);
        else if (i_data > word_t'(`DEPTH_MAX))
            blk_clamped = ptr_t'(`DEPTH_MAX);
        else
            blk_clamped = i_data[`PTR_W:0];
    end

    // zero window would never close
    assign window_clamped = (i_data == '0) ? count_t'(1) : count_t'(i_data);

    ////////////////////////////////////////////////////////////
    // config registers and change pulses
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            blk_size_q      <= ptr_t'(`BLK_DEFAULT);
            window_len_q    <= count_t'(`WIN_DEFAULT);
            blk_change_q    <= 1'b0;
            window_change_q <= 1'b0;
        end
        else
        begin
            // pulse lands in the cycle the new value is visible
            blk_change_q    <= hit_blk;
            window_change_q <= hit_window;
            if (hit_blk)
                blk_size_q <= blk_clamped;
            if (hit_window)
                window_len_q <= window_clamped;
        end
    end

    assign cfg.blk_size      = blk_size_q;
    assign cfg.blk_change    = blk_change_q;
    assign cfg.window_len    = window_len_q;
    assign cfg.window_change = window_change_q;

endmodule

`default_nettype wire

/* hw/spike_cfg_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface spike_cfg_if;

    import spike_delay_pkg::*;

    // block size for both delay stages
    ptr_t   blk_size;
    // one cycle after a block size load
    logic   blk_change;

    // counting window in cycles
    count_t window_len;
    // one cycle after a window length load
    logic   window_change;

    ////////////////////////////////////////////////////////////
    // views per module
    ////////////////////////////////////////////////////////////

    // register side
    modport decode (
        output blk_size,
        output blk_change,
        output window_len,
        output window_change
    );

    // delay line side
    modport execute (
        input blk_size,
        input blk_change
    );

    // counter side
    modport result (
        input window_len,
        input window_change
    );

endinterface

`default_nettype wire

/* hw/spike_count_result.sv */
`timescale 1ns/100ps
`default_nettype none

module spike_count_result (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_spike_raw,
    input  logic                    i_spike_d1,
    input  logic                    i_spike_d2,
    spike_cfg_if.result             cfg,
    output spike_delay_pkg::count_t o_count_raw,
    output spike_delay_pkg::count_t o_count_delayed,
    output spike_delay_pkg::count_t o_count_delayed_twice,
    output logic                    o_count_valid
);

    import spike_delay_pkg::*;

    // raw, once delayed, twice delayed
    localparam int N_TAP = 3;

    logic [N_TAP-1:0] taps;
    count_t           timer_q;
    count_t           timer_cur;
    logic             last;
    count_t           cnt_q   [N_TAP];
    count_t           sum     [N_TAP];
    count_t           count_q [N_TAP];
    logic             valid_q;

    assign taps = {i_spike_d2, i_spike_d1, i_spike_raw};

    ////////////////////////////////////////////////////////////
    // window timer
    ////////////////////////////////////////////////////////////

    // new length takes effect with this cycle as window start
    assign timer_cur = cfg.window_change ? '0 : timer_q;
    assign last      = (timer_cur == cfg.window_len - count_t'(1));

    // running totals include this cycle's spike
    always_comb
    begin
        for (int k = 0; k < N_TAP; k++)
            sum[k] = (cfg.window_change ? '0 : cnt_q[k]) + count_t'(taps[k]);
    end

    ////////////////////////////////////////////////////////////
    // counters and result registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            timer_q <= '0;
            valid_q <= 1'b0;
            for (int k = 0; k < N_TAP; k++)
            begin
                cnt_q[k]   <= '0;
                count_q[k] <= '0;
            end
        end
        else
        begin
            valid_q <= last;
            timer_q <= last ? '0 : timer_cur + count_t'(1);
            for (int k = 0; k < N_TAP; k++)
            begin
                // close the window and start again from zero
                cnt_q[k] <= last ? '0 : sum[k];
                if (last)
                    count_q[k] <= sum[k];
            end
        end
    end

    // held until the next window closes
    assign o_count_raw           = count_q[0];
    assign o_count_delayed       = count_q[1];
    assign o_count_delayed_twice = count_q[2];
    assign o_count_valid         = valid_q;

endmodule

`default_nettype wire

/* hw/spike_delay_macros.svh */
`ifndef SPIKE_DELAY_MACROS_SVH
`define SPIKE_DELAY_MACROS_SVH

// host load word and code widths
`define DATA_W 32
`define CODE_W 4

// spike count width
`define CNT_W 32

// delay buffer depth limit and pointer width
`define DEPTH_MAX 64
`define PTR_W 6

// configuration after reset
`define BLK_DEFAULT 8
`define WIN_DEFAULT 16

// load codes carried with the load strobe
`define CODE_WINDOW 0
`define CODE_BLK 2

`endif

/* hw/spike_delay_pkg.sv */
`default_nettype none

package spike_delay_pkg;

    `include "spike_delay_macros.svh"

    ////////////////////////////////////////////////////////////
    // shared types
    ////////////////////////////////////////////////////////////

    // buffer index or block size
    // one extra bit so DEPTH_MAX itself fits
    typedef logic [`PTR_W:0] ptr_t;

    // spike count per window, also window length
    typedef logic [`CNT_W-1:0] count_t;

    // host data word
    typedef logic [`DATA_W-1:0] word_t;

    // host load code
    typedef logic [`CODE_W-1:0] code_t;

endpackage

`default_nettype wire

/* hw/spike_delay_top.sv */
`timescale 1ns/100ps
`default_nettype none

module spike_delay_top (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_load,
    input  spike_delay_pkg::code_t  i_code,
    input  spike_delay_pkg::word_t  i_data,
    input  logic                    i_spike,
    output logic                    o_spike_delayed,
    output spike_delay_pkg::count_t o_count_raw,
    output spike_delay_pkg::count_t o_count_delayed,
    output spike_delay_pkg::count_t o_count_delayed_twice,
    output logic                    o_count_valid
);

    // three taps from delay line to counters
    logic spike_raw;
    logic spike_d1;
    logic spike_d2;

    ////////////////////////////////////////////////////////////
    // config bus
    ////////////////////////////////////////////////////////////

    spike_cfg_if cfg_bus ();

    param_decode u_decode (
        .i_clk  (i_clk),
        .i_reset(i_reset),
        .i_load (i_load),
        .i_code (i_code),
        .i_data (i_data),
        .cfg    (cfg_bus.decode)
    );

    ////////////////////////////////////////////////////////////
    // delay and count
    ////////////////////////////////////////////////////////////

    delay_line_execute u_execute (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_spike    (i_spike),
        .cfg        (cfg_bus.execute),
        .o_spike_raw(spike_raw),
        .o_spike_d1 (spike_d1),
        .o_spike_d2 (spike_d2)
    );

    spike_count_result u_result (
        .i_clk                (i_clk),
        .i_reset              (i_reset),
        .i_spike_raw          (spike_raw),
        .i_spike_d1           (spike_d1),
        .i_spike_d2           (spike_d2),
        .cfg                  (cfg_bus.result),
        .o_count_raw          (o_count_raw),
        .o_count_delayed      (o_count_delayed),
        .o_count_delayed_twice(o_count_delayed_twice),
        .o_count_valid        (o_count_valid)
    );

    // once delayed train goes off board
    assign o_spike_delayed = spike_d1;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# compile and run the spike delay testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_spike_delay -o sim_tb -f all.f

./obj_dir/sim_tb | tee sim.log

# pass only when the testbench printed its pass line
if grep -qx "Simulation PASSED" sim.log; then
    echo "run_sim: pass"
    exit 0
else
    echo "run_sim: fail, see sim.log"
    exit 1
fi

/* verification/spike_delay_cases.txt */
# block window pattern(hex, bit 0 first) windows raw delayed delayed_twice
# counts are per window once the delay line is full, for the last window of each case

# window a multiple of the pattern period
4 16 00ff00ff 4 8 8 8
8 32 12345678 3 13 13 13
16 64 a5a5a5a5 3 32 32 32
3 24 0f0f0f0f 3 12 12 12
1 8 55555555 4 4 4 4

# deepest block
64 32 ffffffff 6 32 32 32

# quiet input
5 10 00000000 3 0 0 0

# clamped block size and window length
0 0 ffffffff 8 1 1 1
100 64 a5a5a5a5 3 32 32 32
2 0 00000000 6 0 0 0

# mixed sizes
7 12 33333333 4 6 6 6
32 48 000f000f 3 12 12 12
12 20 11111111 3 5 5 5
6 32 80000001 2 2 2 2

# long window, constant input
10 200 ffffffff 2 200 200 200

/* verification/tb_spike_delay.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spike_delay_macros.svh"

module tb_spike_delay;

    import spike_delay_pkg::*;

    localparam int    CLK_PERIOD     = 20;
    localparam int    DRIVE_DELAY    = 2;
    localparam int    HIST_N         = 4096;
    localparam int    RESET_CYCLES   = 64;
    localparam int    UNKNOWN_CYCLES = 48;
    localparam int    CASE_OVERHEAD  = 3;
    localparam int    MARGIN         = 100;
    localparam string CASES_FILE     = "verification/spike_delay_cases.txt";
    // free running input for the sections outside the file cases
    localparam logic [31:0] FREE_PATTERN = 32'hc3a5_1e69;

    logic   ep50trig;
    logic   reset_sim;
    logic   i_load;
    code_t  i_code;
    word_t  i_data;
    logic   i_spike;
    logic   o_spike_delayed;
    count_t o_count_raw;
    count_t o_count_delayed;
    count_t o_count_delayed_twice;
    logic   o_count_valid;

    // cases from the file
    int          c_blk  [$];
    int          c_win  [$];
    logic [31:0] c_pat  [$];
    int          c_nwin [$];
    int          c_raw  [$];
    int          c_d1   [$];
    int          c_d2   [$];

    // reference model state
    bit   hist [HIST_N];
    int   m_blk;
    int   m_win;
    int   m_t;
    int   m_w;
    int   acc_raw;
    int   acc_d1;
    int   acc_d2;
    int   exp_raw;
    int   exp_d1c;
    int   exp_d2c;
    logic exp_valid;

    // last sampled outputs
    logic   s_valid;
    count_t s_raw;
    count_t s_d1;
    count_t s_d2;

    int value_errors      = 0;
    int other_errors      = 0;
    int cycle_index       = 0;
    int first_valid_cycle = -1;
    int cycle_limit       = 0;
    int wd_cycles         = 0;
    bit limit_ready       = 0;

    spike_delay_top uut (
        .i_clk                (ep50trig),
        .i_reset              (reset_sim),
        .i_load               (i_load),
        .i_code               (i_code),
        .i_data               (i_data),
        .i_spike              (i_spike),
        .o_spike_delayed      (o_spike_delayed),
        .o_count_raw          (o_count_raw),
        .o_count_delayed      (o_count_delayed),
        .o_count_delayed_twice(o_count_delayed_twice),
        .o_count_valid        (o_count_valid)
    );

    initial
    begin
        ep50trig = 1'b0;
        forever
            #(CLK_PERIOD / 2) ep50trig = ~ep50trig;
    end

    ////////////////////////////////////////////////////////////
    // compare and config rules
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            value_errors++;
            $display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
        end
    endtask

    // block size kept within 1 .. DEPTH_MAX
    function automatic int clamp_block(input word_t data);
        if (data == 0)
            return 1;
        if (data > `DEPTH_MAX)
            return `DEPTH_MAX;
        return int'(data);
    endfunction

    // window never shorter than one cycle
    function automatic int clamp_window(input word_t data);
        if (data == 0)
            return 1;
        return int'(data);
    endfunction

    ////////////////////////////////////////////////////////////
    // one clock cycle entered 2 ns after a rising edge
    ////////////////////////////////////////////////////////////

    task automatic run_cycle(input logic spike, input logic load,
                             input code_t code, input word_t data);
        logic exp_d1;
        logic exp_d2;
        i_spike = spike;
        i_load  = load;
        i_code  = code;
        i_data  = data;
        // taps stay 0 until enough history since the last restart
        exp_d1 = (m_t >= m_blk) ? hist[(m_t - m_blk) % HIST_N] : 1'b0;
        exp_d2 = (m_t >= 2 * m_blk) ? hist[(m_t - 2 * m_blk) % HIST_N] : 1'b0;
        // outputs settled by mid cycle
        @(negedge ep50trig);
        s_valid = o_count_valid;
        s_raw   = o_count_raw;
        s_d1    = o_count_delayed;
        s_d2    = o_count_delayed_twice;
        check_value("o_spike_delayed", 32'(o_spike_delayed), 32'(exp_d1));
        check_value("o_count_valid", 32'(o_count_valid), 32'(exp_valid));
        check_value("o_count_raw", o_count_raw, exp_raw);
        check_value("o_count_delayed", o_count_delayed, exp_d1c);
        check_value("o_count_delayed_twice", o_count_delayed_twice, exp_d2c);
        if (o_count_valid === 1'b1 && first_valid_cycle < 0)
            first_valid_cycle = cycle_index;
        // model advance
        hist[m_t % HIST_N] = spike;
        acc_raw = acc_raw + (spike ? 1 : 0);
        acc_d1  = acc_d1 + (exp_d1 ? 1 : 0);
        acc_d2  = acc_d2 + (exp_d2 ? 1 : 0);
        if (m_w == m_win - 1)
        begin
            // results of the closing window show next cycle
            exp_raw   = acc_raw;
            exp_d1c   = acc_d1;
            exp_d2c   = acc_d2;
            acc_raw   = 0;
            acc_d1    = 0;
            acc_d2    = 0;
            m_w       = 0;
            exp_valid = 1'b1;
        end
        else
        begin
            m_w++;
            exp_valid = 1'b0;
        end
        m_t++;
        // loads take effect from the next cycle
        if (load && code == code_t'(`CODE_BLK))
        begin
            m_blk = clamp_block(data);
            m_t   = 0;
        end
        if (load && code == code_t'(`CODE_WINDOW))
        begin
            m_win   = clamp_window(data);
            m_w     = 0;
            acc_raw = 0;
            acc_d1  = 0;
            acc_d2  = 0;
        end
        cycle_index++;
        @(posedge ep50trig);
        #DRIVE_DELAY;
    endtask

    ////////////////////////////////////////////////////////////
    // cases file
    ////////////////////////////////////////////////////////////

    task automatic load_cases();
        int          fd;
        int          rc;
        int          n;
        int          blk;
        int          win;
        int          nwin;
        int          er;
        int          e1;
        int          e2;
        logic [31:0] pat;
        string       line;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0)
        begin
            $display("cannot open cases file %s", CASES_FILE);
            other_errors++;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            rc = $fgets(line, fd);
            // comment and blank lines do not parse
            if (rc != 0)
            begin
                n = $sscanf(line, "%d %d %h %d %d %d %d", blk, win, pat, nwin, er, e1, e2);
                if (n == 7)
                begin
                    c_blk.push_back(blk);
                    c_win.push_back(win);
                    c_pat.push_back(pat);
                    c_nwin.push_back(nwin);
                    c_raw.push_back(er);
                    c_d1.push_back(e1);
                    c_d2.push_back(e2);
                end
            end
        end
        $fclose(fd);
        if (c_blk.size() == 0)
        begin
            $display("no cases found in %s", CASES_FILE);
            other_errors++;
        end
    endtask

    // all windows of all cases plus both refills and the fixed sections
    function automatic int cycle_budget();
        int total;
        total = RESET_CYCLES + UNKNOWN_CYCLES + 2 * `DEPTH_MAX + MARGIN;
        foreach (c_nwin[i])
            total += c_nwin[i] * clamp_window(word_t'(c_win[i])) + CASE_OVERHEAD;
        return total;
    endfunction

    // block load, window load, pattern, then one cycle for the last pulse
    task automatic run_case(input int idx);
        int          n_cycles;
        int          valid_seen;
        int          p;
        logic [31:0] pat;
        pat      = c_pat[idx];
        n_cycles = c_nwin[idx] * clamp_window(word_t'(c_win[idx]));
        run_cycle(1'b0, 1'b1, code_t'(`CODE_BLK), word_t'(c_blk[idx]));
        run_cycle(1'b0, 1'b1, code_t'(`CODE_WINDOW), word_t'(c_win[idx]));
        valid_seen = 0;
        for (p = 0; p < n_cycles; p++)
        begin
            run_cycle(pat[p % 32], 1'b0, '0, '0);
            // a pulse in the first pattern cycle is from the old window
            if (p >= 1 && s_valid === 1'b1)
                valid_seen++;
        end
        run_cycle(1'b0, 1'b0, '0, '0);
        if (s_valid === 1'b1)
            valid_seen++;
        if (valid_seen != c_nwin[idx])
        begin
            $display("case %0d: expected %0d count valid pulses, saw %0d",
                     idx, c_nwin[idx], valid_seen);
            other_errors++;
        end
        // last window is past the fill time
        check_value("o_count_raw", s_raw, c_raw[idx]);
        check_value("o_count_delayed", s_d1, c_d1[idx]);
        check_value("o_count_delayed_twice", s_d2, c_d2[idx]);
    endtask

    ////////////////////////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////////////////////////

    initial
    begin
        wait (limit_ready);
        while (wd_cycles <= cycle_limit)
        begin
            @(posedge ep50trig);
            wd_cycles++;
        end
        $display("timeout: run not finished after %0d cycles", cycle_limit);
        $display("Simulation FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        reset_sim = 1'b1;
        i_load    = 1'b0;
        i_code    = '0;
        i_data    = '0;
        i_spike   = 1'b0;
        // model starts from the reset defaults
        m_blk     = `BLK_DEFAULT;
        m_win     = `WIN_DEFAULT;
        m_t       = 0;
        m_w       = 0;
        acc_raw   = 0;
        acc_d1    = 0;
        acc_d2    = 0;
        exp_raw   = 0;
        exp_d1c   = 0;
        exp_d2c   = 0;
        exp_valid = 1'b0;
        load_cases();
        cycle_limit = cycle_budget();
        limit_ready = 1;
        repeat (4) @(posedge ep50trig);
        #DRIVE_DELAY;
        reset_sim = 1'b0;

        // defaults of B=8 and a 16 cycle window
        repeat (RESET_CYCLES)
            run_cycle(FREE_PATTERN[cycle_index % 32], 1'b0, '0, '0);
        check_value("first o_count_valid cycle", 32'(first_valid_cycle), 32'(`WIN_DEFAULT));

        // unknown codes leave both registers alone
        run_cycle(FREE_PATTERN[cycle_index % 32], 1'b1, code_t'(5), word_t'(3));
        run_cycle(FREE_PATTERN[cycle_index % 32], 1'b1, code_t'(1), word_t'(7));
        run_cycle(FREE_PATTERN[cycle_index % 32], 1'b1, code_t'(15), word_t'(0));
        repeat (UNKNOWN_CYCLES - 3)
            run_cycle(FREE_PATTERN[cycle_index % 32], 1'b0, '0, '0);

        foreach (c_blk[i])
            run_case(i);

        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire
